// ==== icache_pkg.sv ====
package icache_pkg;

	// ----------------------------------------
	// bus widths
	// ----------------------------------------

	// byte address on both read ports
	typedef logic [31:0] addr_t;

	// one instruction word, also one cache line
	typedef logic [31:0] word_t;

	// satp page-number field, tags every line
	typedef logic [19:0] asid_t;

	// ----------------------------------------
	// read response codes
	// ----------------------------------------

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// ----------------------------------------
	// line geometry
	// ----------------------------------------

	// byte offset inside a one-word line
	localparam int OFFSET_BITS = 2;

	// ----------------------------------------
	// controller FSM
	// ----------------------------------------

	typedef enum logic [1:0] {
		st_idle,
		st_wait_mem_ar,
		st_wait_mem_r,
		st_wait_ifu_r
	} icache_state_e;

endpackage

// ==== icache_tag_if.sv ====
`timescale 1ns/1ns

interface icache_tag_if #(
	parameter int INDEX_BITS = 4
);
	import icache_pkg::*;

	localparam int TAG_BITS = 32 - OFFSET_BITS - INDEX_BITS;

	// lookup request, steered by the controller
	addr_t lookup_addr;
	asid_t lookup_asid;
	// lookup result from the store
	logic  hit;
	logic  any_valid;
	// fill of one line and flush of all lines
	logic  fill_en;
	addr_t fill_addr;
	asid_t fill_asid;
	logic  flush_all;

	// address split, kept here so both sides agree on it
	logic [INDEX_BITS-1:0] lookup_index;
	logic [TAG_BITS-1:0]   lookup_tag;
	logic [INDEX_BITS-1:0] fill_index;
	logic [TAG_BITS-1:0]   fill_tag;

	assign lookup_index = lookup_addr[OFFSET_BITS +: INDEX_BITS];
	assign lookup_tag   = lookup_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
	assign fill_index   = fill_addr[OFFSET_BITS +: INDEX_BITS];
	assign fill_tag     = fill_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];

	modport ctrl (
		output lookup_addr, lookup_asid, fill_en, fill_addr, fill_asid, flush_all,
		input  hit, any_valid
	);

	modport store (
		input  lookup_index, lookup_tag, lookup_asid,
		input  fill_en, fill_index, fill_tag, fill_asid, flush_all,
		output hit, any_valid
	);

endinterface

// ==== icache_tag_store.sv ====
`timescale 1ns/1ns

module icache_tag_store #(
	parameter int INDEX_BITS = 4
)(
	input logic         clk,
	input logic         rst,
	icache_tag_if.store tag
);
	import icache_pkg::*;

	localparam int LINES    = 1 << INDEX_BITS;
	localparam int TAG_BITS = 32 - OFFSET_BITS - INDEX_BITS;

	typedef logic [TAG_BITS-1:0] line_tag_t;

	// ----------------------------------------
	// line state
	// ----------------------------------------

	// one valid bit per line, the only state under reset
	logic [LINES-1:0] valid_q;
	// upper address bits of the cached word
	line_tag_t        tag_mem [LINES];
	// address space the word was fetched in
	asid_t            asid_mem [LINES];

	// valid bits: flush wins, fill sets one
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (tag.flush_all) begin
			valid_q <= '0;
		end else if (tag.fill_en) begin
			valid_q[tag.fill_index] <= 1'b1;
		end
	end

	// tag and asid written alongside the data word
	always_ff @(posedge clk) begin
		if (tag.fill_en) begin
			tag_mem[tag.fill_index]  <= tag.fill_tag;
			asid_mem[tag.fill_index] <= tag.fill_asid;
		end
	end

	// ----------------------------------------
	// lookup
	// ----------------------------------------

	// hit needs valid line, same tag and same address space
	assign tag.hit = valid_q[tag.lookup_index]
		&& (tag_mem[tag.lookup_index] == tag.lookup_tag)
		&& (asid_mem[tag.lookup_index] == tag.lookup_asid);

	// lets the controller skip a flush of an already empty cache
	assign tag.any_valid = |valid_q;

	// controller must never fill and flush in one cycle
	assert property (@(posedge clk) disable iff (rst)
		!(tag.fill_en && tag.flush_all))
		else $error("icache_tag_store: fill_en and flush_all high together");

endmodule

// ==== icache_data_store.sv ====
`timescale 1ns/1ns

module icache_data_store #(
	parameter int INDEX_BITS = 4
)(
	input  logic              clk,
	input  icache_pkg::addr_t rd_addr,
	output icache_pkg::word_t rd_data,
	input  logic              wr_en,
	input  icache_pkg::addr_t wr_addr,
	input  icache_pkg::word_t wr_data
);
	import icache_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;

	// one instruction word per line
	word_t mem [LINES];

	logic [INDEX_BITS-1:0] rd_index;
	logic [INDEX_BITS-1:0] wr_index;

	// index sits right above the byte offset
	assign rd_index = rd_addr[OFFSET_BITS +: INDEX_BITS];
	assign wr_index = wr_addr[OFFSET_BITS +: INDEX_BITS];

	// ----------------------------------------
	// array access
	// ----------------------------------------

	// fill from the memory response
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_index] <= wr_data;
		end
	end

	// combinational read, hit data goes out the same cycle
	assign rd_data = mem[rd_index];

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl #(
	parameter int INDEX_BITS = 4
)(
	input  logic              clk,
	input  logic              rst,
	// fetch side
	input  icache_pkg::addr_t ifu_araddr,
	input  logic              ifu_arvalid,
	output logic              ifu_arready,
	output icache_pkg::word_t ifu_rdata,
	output icache_pkg::resp_t ifu_rresp,
	output logic              ifu_rvalid,
	input  logic              ifu_rready,
	// memory side
	output icache_pkg::addr_t mem_araddr,
	output logic              mem_arvalid,
	input  logic              mem_arready,
	input  icache_pkg::word_t mem_rdata,
	input  icache_pkg::resp_t mem_rresp,
	input  logic              mem_rvalid,
	output logic              mem_rready,
	// invalidation and address space
	input  logic              fence_i,
	input  icache_pkg::addr_t satp,
	// tag store and data store
	icache_tag_if.ctrl        tag,
	output icache_pkg::addr_t data_rd_addr,
	input  icache_pkg::word_t data_rd_data,
	output logic              data_wr_en,
	output icache_pkg::addr_t data_wr_addr,
	output icache_pkg::word_t data_wr_data
);
	import icache_pkg::*;

	icache_state_e state_q;
	logic          fence_pend_q;
	// request and response payload
	addr_t req_addr_q;
	asid_t req_asid_q;
	word_t rdata_q;
	resp_t rresp_q;

	logic  idle;
	logic  fence_now;
	logic  accept;
	logic  hit_fire;
	logic  mem_done;
	logic  fill_ok;
	addr_t lookup_addr;
	asid_t live_asid;

	// index must leave room for a tag
	initial assert (INDEX_BITS >= 1 && INDEX_BITS < 32 - OFFSET_BITS)
		else $fatal(1, "icache_ctrl: INDEX_BITS out of range");

	// ----------------------------------------
	// decode
	// ----------------------------------------

	assign idle      = (state_q == st_idle);
	// fence seen now or held over from a busy period
	assign fence_now = fence_i || fence_pend_q;
	assign live_asid = satp[31:12];
	assign accept    = ifu_arready && ifu_arvalid;
	assign hit_fire  = accept && tag.hit;
	assign mem_done  = (state_q == st_wait_mem_r) && mem_rvalid;
	// error responses are forwarded but never cached
	assign fill_ok   = mem_done && (mem_rresp == RESP_OKAY);

	// idle looks up the live fetch address, otherwise the held request
	assign lookup_addr     = idle ? ifu_araddr : req_addr_q;
	assign tag.lookup_addr = lookup_addr;
	assign tag.lookup_asid = idle ? live_asid : req_asid_q;
	assign data_rd_addr    = lookup_addr;

	// fill path
	assign tag.fill_en   = fill_ok;
	assign tag.fill_addr = req_addr_q;
	assign tag.fill_asid = req_asid_q;
	assign data_wr_en    = fill_ok;
	assign data_wr_addr  = req_addr_q;
	assign data_wr_data  = mem_rdata;

	// flush only when idle and something is still valid
	assign tag.flush_all = idle && fence_now && tag.any_valid;

	// ----------------------------------------
	// handshake outputs
	// ----------------------------------------

	assign ifu_arready = idle && !fence_now;
	// hit answers in the accept cycle, else from the latch
	assign ifu_rvalid  = hit_fire || (state_q == st_wait_ifu_r);
	assign ifu_rdata   = (state_q == st_wait_ifu_r) ? rdata_q : data_rd_data;
	assign ifu_rresp   = (state_q == st_wait_ifu_r) ? rresp_q : RESP_OKAY;
	assign mem_araddr  = {req_addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign mem_arvalid = (state_q == st_wait_mem_ar);
	assign mem_rready  = (state_q == st_wait_mem_r);

	// FSM and pending fence
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q      <= st_idle;
			fence_pend_q <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (fence_now) begin
						// flush happens this edge, fence consumed
						fence_pend_q <= 1'b0;
					end else if (ifu_arvalid) begin
						if (!tag.hit) begin
							state_q <= st_wait_mem_ar;
						end else if (!ifu_rready) begin
							state_q <= st_wait_ifu_r;
						end
					end
				end
				st_wait_mem_ar: begin
					if (mem_arready) begin
						state_q <= st_wait_mem_r;
					end
				end
				st_wait_mem_r: begin
					if (mem_rvalid) begin
						state_q <= st_wait_ifu_r;
					end
				end
				st_wait_ifu_r: begin
					if (ifu_rready) begin
						state_q <= st_idle;
					end
				end
				default: state_q <= st_idle;
			endcase
			// busy, so remember the fence for the next idle cycle
			if (!idle && fence_i) begin
				fence_pend_q <= 1'b1;
			end
		end
	end

	// payload latches
	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr_q <= ifu_araddr;
			req_asid_q <= live_asid;
		end
		if (hit_fire) begin
			rdata_q <= data_rd_data;
			rresp_q <= RESP_OKAY;
		end else if (mem_done) begin
			rdata_q <= mem_rdata;
			rresp_q <= mem_rresp;
		end
	end

	// ----------------------------------------
	// protocol checks
	// ----------------------------------------

	// address request held with a stable address until taken
	assert property (@(posedge clk) disable iff (rst)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else $error("icache_ctrl: mem_arvalid dropped before mem_arready");

	// fetch response held until the fetch unit takes it
	assert property (@(posedge clk) disable iff (rst)
		ifu_rvalid && !ifu_rready |=> ifu_rvalid)
		else $error("icache_ctrl: ifu_rvalid dropped before ifu_rready");

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ns

module icache_top #(
	parameter int INDEX_BITS = 4
)(
	input  logic              clk,
	input  logic              rst,
	// fetch side read port
	input  icache_pkg::addr_t ifu_araddr,
	input  logic              ifu_arvalid,
	output logic              ifu_arready,
	output icache_pkg::word_t ifu_rdata,
	output icache_pkg::resp_t ifu_rresp,
	output logic              ifu_rvalid,
	input  logic              ifu_rready,
	// memory side read port
	output icache_pkg::addr_t mem_araddr,
	output logic              mem_arvalid,
	input  logic              mem_arready,
	input  icache_pkg::word_t mem_rdata,
	input  icache_pkg::resp_t mem_rresp,
	input  logic              mem_rvalid,
	output logic              mem_rready,
	// fence pulse and current satp
	input  logic              fence_i,
	input  icache_pkg::addr_t satp
);
	import icache_pkg::*;

	// data array path
	addr_t data_rd_addr;
	word_t data_rd_data;
	logic  data_wr_en;
	addr_t data_wr_addr;
	word_t data_wr_data;

	// ----------------------------------------
	// tag lookup and update path
	// ----------------------------------------

	icache_tag_if #(.INDEX_BITS(INDEX_BITS)) i_tag_if ();

	icache_tag_store #(.INDEX_BITS(INDEX_BITS)) i_tag_store (
		.clk (clk),
		.rst (rst),
		.tag (i_tag_if.store)
	);

	// word array, no reset
	icache_data_store #(.INDEX_BITS(INDEX_BITS)) i_data_store (
		.clk     (clk),
		.rd_addr (data_rd_addr),
		.rd_data (data_rd_data),
		.wr_en   (data_wr_en),
		.wr_addr (data_wr_addr),
		.wr_data (data_wr_data)
	);

	// FSM and both handshakes
	icache_ctrl #(.INDEX_BITS(INDEX_BITS)) i_ctrl (
		.clk          (clk),
		.rst          (rst),
		.ifu_araddr   (ifu_araddr),
		.ifu_arvalid  (ifu_arvalid),
		.ifu_arready  (ifu_arready),
		.ifu_rdata    (ifu_rdata),
		.ifu_rresp    (ifu_rresp),
		.ifu_rvalid   (ifu_rvalid),
		.ifu_rready   (ifu_rready),
		.mem_araddr   (mem_araddr),
		.mem_arvalid  (mem_arvalid),
		.mem_arready  (mem_arready),
		.mem_rdata    (mem_rdata),
		.mem_rresp    (mem_rresp),
		.mem_rvalid   (mem_rvalid),
		.mem_rready   (mem_rready),
		.fence_i      (fence_i),
		.satp         (satp),
		.tag          (i_tag_if.ctrl),
		.data_rd_addr (data_rd_addr),
		.data_rd_data (data_rd_data),
		.data_wr_en   (data_wr_en),
		.data_wr_addr (data_wr_addr),
		.data_wr_data (data_wr_data)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 5
)(
	output logic clk,
	output logic rst
);
	// free running clock, 50 percent duty
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset held for the first few rising edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== icache_tb.sv ====
`timescale 1ns/1ns

module icache_tb;
	import icache_pkg::*;

	localparam int          INDEX_BITS      = 4;
	localparam int          LINES           = 1 << INDEX_BITS;
	localparam int          NUM_REQ         = 300;
	localparam int          CLK_PERIOD      = 40;
	// worst case of 12 cycles per request plus reset
	localparam int          WATCHDOG_CYCLES = NUM_REQ * 12 + 5;
	// 64 words so four tags share every index
	localparam addr_t       ADDR_BASE       = 32'h0000_1000;
	// top quarter of the range answers with an error
	localparam addr_t       ERR_LO          = 32'h0000_10c0;
	localparam addr_t       ERR_HI          = 32'h0000_10ff;
	localparam word_t       DATA_KEY        = 32'h5a5a_c3c3;
	localparam logic [31:0] SEED            = 32'hf1019cc1;

	logic  clk;
	logic  rst;
	addr_t ifu_araddr  = '0;
	logic  ifu_arvalid = 1'b0;
	logic  ifu_arready;
	word_t ifu_rdata;
	resp_t ifu_rresp;
	logic  ifu_rvalid;
	logic  ifu_rready  = 1'b0;
	addr_t mem_araddr;
	logic  mem_arvalid;
	logic  mem_arready = 1'b0;
	word_t mem_rdata   = '0;
	resp_t mem_rresp   = RESP_OKAY;
	logic  mem_rvalid  = 1'b0;
	logic  mem_rready;
	logic  fence_i     = 1'b0;
	addr_t satp        = '0;

	// shadow cache keeps a word address per line
	logic [LINES-1:0]      sh_valid;
	logic [29:0]           sh_line [LINES];
	asid_t                 sh_asid [LINES];
	logic                  fence_pend;
	logic                  busy;
	addr_t                 req_addr;
	asid_t                 req_asid;
	logic                  req_miss;
	logic                  miss_q;
	logic                  rst_d = 1'b0;
	logic [INDEX_BITS-1:0] cur_index;
	logic [INDEX_BITS-1:0] req_index;
	logic                  accept;
	logic                  pred_hit;
	addr_t                 resp_addr;
	word_t                 exp_data;
	resp_t                 exp_resp;
	// memory model state
	addr_t                 mem_addr;
	logic                  r_pending = 1'b0;
	int unsigned           ar_delay  = 0;
	int unsigned           r_delay   = 0;
	// run bookkeeping
	int                    value_errors    = 0;
	int                    protocol_errors = 0;
	int                    served          = 0;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) i_clock_gen (.clk(clk), .rst(rst));

	icache_top #(.INDEX_BITS(INDEX_BITS)) i_icache_top (
		.clk(clk), .rst(rst),
		.ifu_araddr(ifu_araddr), .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready),
		.ifu_rdata(ifu_rdata), .ifu_rresp(ifu_rresp),
		.ifu_rvalid(ifu_rvalid), .ifu_rready(ifu_rready),
		.mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
		.mem_rdata(mem_rdata), .mem_rresp(mem_rresp),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
		.fence_i(fence_i), .satp(satp)
	);

	function automatic logic in_err_region(input addr_t a);
		return (a >= ERR_LO) && (a <= ERR_HI);
	endfunction

	task automatic note_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		value_errors++;
		$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic note_protocol_error(input string what);
		protocol_errors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	// ----------------------------------------
	// expected values from the shadow cache
	// ----------------------------------------

	assign accept    = ifu_arvalid && ifu_arready;
	assign cur_index = ifu_araddr[OFFSET_BITS +: INDEX_BITS];
	assign req_index = req_addr[OFFSET_BITS +: INDEX_BITS];
	// same word address and same address space
	assign pred_hit  = sh_valid[cur_index] && (sh_line[cur_index] == ifu_araddr[31:2])
		&& (sh_asid[cur_index] == satp[31:12]);
	// hit answers in the accept cycle and all else from the held request
	assign resp_addr = accept ? ifu_araddr : req_addr;
	assign exp_data  = {resp_addr[31:2], 2'b00} ^ DATA_KEY;
	assign exp_resp  = in_err_region(resp_addr) ? RESP_SLVERR : RESP_OKAY;

	always @(posedge clk) begin
		rst_d <= rst;
		if (rst) begin
			sh_valid   <= '0;
			fence_pend <= 1'b0;
			busy       <= 1'b0;
			req_miss   <= 1'b0;
			miss_q     <= 1'b0;
		end else begin
			miss_q <= accept && !pred_hit;
			if (accept) begin
				req_addr <= ifu_araddr;
				req_asid <= satp[31:12];
				req_miss <= !pred_hit;
			end
			busy <= (busy || accept) && !(ifu_rvalid && ifu_rready);
			// only an OKAY response fills
			if (mem_rvalid && mem_rready && mem_rresp == RESP_OKAY) begin
				sh_valid[req_index] <= 1'b1;
				sh_line[req_index]  <= req_addr[31:2];
				sh_asid[req_index]  <= req_asid;
			end
			// fence clears all when idle and waits when busy
			if (!busy && (fence_i || fence_pend)) begin
				sh_valid   <= '0;
				fence_pend <= 1'b0;
			end else if (busy && fence_i) begin
				fence_pend <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// reset edges and the first cycle after
	always @(posedge clk) begin
		if (rst_d) begin
			assert (!ifu_rvalid) else note_mismatch("ifu_rvalid", 32'(ifu_rvalid), 32'd0);
			assert (!mem_arvalid) else note_mismatch("mem_arvalid", 32'(mem_arvalid), 32'd0);
			assert (!mem_rready) else note_mismatch("mem_rready", 32'(mem_rready), 32'd0);
		end
		if (!rst) begin
			if (fence_i) begin
				assert (!ifu_arready)
					else note_mismatch("ifu_arready", 32'(ifu_arready), 32'd0);
			end
			// hit answers at once while a miss stays silent
			if (accept) begin
				assert (ifu_rvalid == pred_hit)
					else note_mismatch("ifu_rvalid", 32'(ifu_rvalid), 32'(pred_hit));
			end
			if (miss_q) begin
				assert (mem_arvalid)
					else note_mismatch("mem_arvalid", 32'(mem_arvalid), 32'd1);
			end
			if (mem_arvalid) begin
				assert (busy && req_miss)
					else note_protocol_error("memory read issued for a predicted hit");
				assert (mem_araddr == {req_addr[31:2], 2'b00})
					else note_mismatch("mem_araddr", mem_araddr, {req_addr[31:2], 2'b00});
			end
			if (ifu_rvalid && ifu_rready) begin
				assert (ifu_rdata == exp_data)
					else note_mismatch("ifu_rdata", ifu_rdata, exp_data);
				assert (ifu_rresp == exp_resp)
					else note_mismatch("ifu_rresp", 32'(ifu_rresp), 32'(exp_resp));
			end
		end
	end

	// valid held with stable payload under back-pressure
	assert property (@(posedge clk) disable iff (rst)
		ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rresp))
		else note_protocol_error("fetch response dropped or changed before ifu_rready");

	assert property (@(posedge clk) disable iff (rst)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else note_protocol_error("memory request dropped or changed before mem_arready");

	// ----------------------------------------
	// memory model and random side inputs
	// ----------------------------------------

	always @(posedge clk) begin
		if (rst) begin
			mem_arready <= 1'b0;
			mem_rvalid  <= 1'b0;
			r_pending   <= 1'b0;
		end else begin
			if (mem_arvalid && mem_arready) begin
				mem_arready <= 1'b0;
				mem_addr    <= mem_araddr;
				r_pending   <= 1'b1;
				r_delay     <= $urandom_range(0, 3);
				ar_delay    <= $urandom_range(0, 3);
			end else if (mem_arvalid) begin
				if (ar_delay == 0) begin
					mem_arready <= 1'b1;
				end else begin
					ar_delay <= ar_delay - 1;
				end
			end
			if (mem_rvalid && mem_rready) begin
				mem_rvalid <= 1'b0;
				r_pending  <= 1'b0;
			end else if (r_pending && !mem_rvalid) begin
				if (r_delay == 0) begin
					mem_rvalid <= 1'b1;
					mem_rdata  <= mem_addr ^ DATA_KEY;
					mem_rresp  <= in_err_region(mem_addr) ? RESP_SLVERR : RESP_OKAY;
				end else begin
					r_delay <= r_delay - 1;
				end
			end
		end
	end

	// fetch stalls about one cycle in four
	always @(posedge clk) ifu_rready <= !rst && ($urandom_range(0, 3) != 0);

	// rare fence pulses that sometimes land during a miss
	always @(posedge clk) fence_i <= !rst && ($urandom_range(0, 47) == 0);

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	initial begin
		void'($urandom(SEED));
		@(negedge rst);
		for (int n = 0; n < NUM_REQ; n++) begin
			@(posedge clk);
			// occasional switch of address space
			if ($urandom_range(0, 31) == 0) begin
				satp <= $urandom_range(0, 2) << 12;
			end
			// any byte of a word so the low address bits get exercised
			ifu_araddr  <= ADDR_BASE | $urandom_range(0, 255);
			ifu_arvalid <= 1'b1;
			do @(posedge clk); while (!(ifu_arvalid && ifu_arready));
			ifu_arvalid <= 1'b0;
			while (!(ifu_rvalid && ifu_rready)) @(posedge clk);
			served++;
		end
		repeat (4) @(posedge clk);
		$display("summary: %0d requests, %0d value errors, %0d protocol errors",
			served, value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// hang guard
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired, %0d of %0d requests served", served, NUM_REQ);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== icache_top.f ====
icache_pkg.sv
icache_tag_if.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
tb_clock_gen.sv
icache_tb.sv

// ==== Makefile ====
# Verilator build and run of the icache testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f icache_top.f
	./obj_dir/Vicache_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Simulation finished: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
